/* exe_stage.f */
logic/exe_pkg.sv
logic/lane_result_if.sv
logic/ex_lane.sv
logic/div_ctrl.sv
logic/div_datapath.sv
logic/ex_resolve.sv
logic/ex_mem_reg.sv
logic/exe_stage.sv
dv/exe_stage_assertions.sv
dv/exe_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module exe_stage_tb -f exe_stage.f

output=$(./obj_dir/Vexe_stage_tb +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* dv/exe_stage_tb.sv */
`timescale 1ns/100ps

module exe_stage_tb;
    import exe_pkg::*;

    localparam int NUM_BUNDLES = 400;
    localparam int DIV_CYCLES  = XLEN + 1;   // pause length of one divide
    localparam int MAX_CYCLES  = NUM_BUNDLES * (XLEN + 8) + 100;
    localparam int SHAMT_W     = $clog2(XLEN);

    logic                 clk;
    logic                 reset_i;
    logic                 flush_i;
    logic                 pause_mem_i;
    logic                 dcache_busy_i;
    logic [NUM_LANES-1:0] valid_i;
    word_t                pc_i      [NUM_LANES];
    alu_op_e              op_i      [NUM_LANES];
    word_t                src1_i    [NUM_LANES];
    word_t                src2_i    [NUM_LANES];
    word_t                imm_i     [NUM_LANES];
    logic [NUM_LANES-1:0] wb_en_i;
    reg_addr_t            wb_addr_i [NUM_LANES];
    logic                 dc_ren_o;
    logic [3:0]           dc_wstrb_o;
    word_t                dc_addr_o;
    word_t                dc_wdata_o;
    logic                 pause_ex_o;
    logic                 branch_flush_o;
    word_t                branch_target_o;
    logic [NUM_LANES-1:0] mem_valid_o;
    logic [NUM_LANES-1:0] mem_wb_en_o;
    reg_addr_t            mem_wb_addr_o [NUM_LANES];
    word_t                mem_wb_data_o [NUM_LANES];

    // model copy of the EX/MEM register
    logic [NUM_LANES-1:0] exp_valid;
    logic [NUM_LANES-1:0] exp_wb_en;
    reg_addr_t            exp_wb_addr [NUM_LANES];
    word_t                exp_wb_data [NUM_LANES];
    logic                 exp_pause;
    logic                 retire;      // bundle leaves dispatch at the coming edge
    int                   div_age;     // cycles the current divide has been presented
    int                   stall_run;
    int                   retired;
    int                   errors;
    int                   checks;
    int                   cycles = 0;
    int                   seed;

    exe_stage uut (.*);

    bind exe_stage exe_stage_assertions u_assertions (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .dcache_busy_i  (dcache_busy_i),
        .dc_ren_i       (dc_ren_o),
        .dc_wstrb_i     (dc_wstrb_o),
        .dc_addr_i      (dc_addr_o),
        .dc_wdata_i     (dc_wdata_o),
        .pause_ex_i     (pause_ex_o),
        .branch_flush_i (branch_flush_o),
        .mem_valid_i    (mem_valid_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout, run still going after %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // corner values show up often enough to hit zero divisors and equal compares
    function automatic word_t rand_operand();
        case (rand_below(8))
            0:       return '0;
            1:       return word_t'(rand_below(16));
            2:       return '1;
            default: return rand_word();
        endcase
    endfunction

    function automatic logic is_mem(alu_op_e op);
        return (op == OP_LD) || (op == OP_ST);
    endfunction

    function automatic logic is_div(alu_op_e op);
        return (op == OP_DIVU) || (op == OP_REMU);
    endfunction

    function automatic logic branch_taken(logic v, alu_op_e op, word_t a, word_t b);
        return v && (((op == OP_BEQ) && (a == b)) || ((op == OP_BNE) && (a != b)));
    endfunction

    function automatic word_t lane_value(alu_op_e op, word_t a, word_t b, word_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[SHAMT_W-1:0];
            OP_SRL:  return a >> b[SHAMT_W-1:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            OP_LD:   return a + imm;
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    task automatic check_bit(string name, logic got, logic expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Fail %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_word(string name, word_t got, word_t expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Fail %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic draw_bundle();
        op_i[0] = alu_op_e'(rand_below(15));
        op_i[1] = alu_op_e'(rand_below(13));   // no divide on lane 1
        if ((is_mem(op_i[0]) || is_div(op_i[0])) && is_mem(op_i[1]))
            op_i[1] = OP_ADD;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            valid_i[l]   = (rand_below(8) != 0);
            pc_i[l]      = rand_word();
            src1_i[l]    = rand_operand();
            src2_i[l]    = (rand_below(4) == 0) ? src1_i[l] : rand_operand();
            imm_i[l]     = rand_operand();
            wb_en_i[l]   = (op_i[l] != OP_NOP) && (rand_below(4) != 0);
            wb_addr_i[l] = reg_addr_t'(rand_below(32));
        end
    endtask

    task automatic draw_controls();
        flush_i       = (rand_below(64) == 0);
        pause_mem_i   = (rand_below(4) == 0);
        dcache_busy_i = (rand_below(4) == 0);
    endtask

    task automatic check_comb();
        logic       mem_any;
        logic       taken0;
        logic       taken1;
        logic       exp_ren;
        logic [3:0] exp_wstrb;
        word_t      exp_addr;
        word_t      exp_wdata;
        int         s;
        s       = (valid_i[0] && is_mem(op_i[0])) ? 0 : 1;   // lane 0 has priority
        mem_any = (valid_i[0] && is_mem(op_i[0])) || (valid_i[1] && is_mem(op_i[1]));
        taken0  = branch_taken(valid_i[0], op_i[0], src1_i[0], src2_i[0]);
        taken1  = branch_taken(valid_i[1], op_i[1], src1_i[1], src2_i[1]);
        exp_pause = (mem_any && dcache_busy_i) ||
                    (valid_i[0] && is_div(op_i[0]) && (div_age < DIV_CYCLES));
        check_bit("pause_ex_o", pause_ex_o, exp_pause);
        exp_ren   = 1'b0;
        exp_wstrb = 4'h0;
        exp_addr  = '0;
        exp_wdata = '0;
        if (mem_any && !dcache_busy_i)
        begin
            exp_ren   = (op_i[s] == OP_LD);
            exp_wstrb = (op_i[s] == OP_ST) ? WSTRB_FULL : 4'h0;
            exp_addr  = src1_i[s] + imm_i[s];
            exp_wdata = (op_i[s] == OP_ST) ? src2_i[s] : '0;
        end
        check_bit("dc_ren_o", dc_ren_o, exp_ren);
        check_word("dc_wstrb_o", word_t'(dc_wstrb_o), word_t'(exp_wstrb));
        check_word("dc_addr_o", dc_addr_o, exp_addr);
        check_word("dc_wdata_o", dc_wdata_o, exp_wdata);
        check_bit("branch_flush_o", branch_flush_o,
                  (taken0 || taken1) && !exp_pause && !pause_mem_i);
        if (taken0 || taken1)
            check_word("branch_target_o", branch_target_o,
                       taken0 ? pc_i[0] + imm_i[0] : pc_i[1] + imm_i[1]);
    endtask

    // applies the EX/MEM priority for the coming edge
    task automatic update_model();
        logic kill;
        kill   = branch_taken(valid_i[0], op_i[0], src1_i[0], src2_i[0]);
        retire = flush_i || (!pause_mem_i && !exp_pause);
        if (flush_i)
        begin
            exp_valid = '0;
            exp_wb_en = '0;
        end
        else if (pause_mem_i)
        begin
            exp_valid = exp_valid;
        end
        else if (exp_pause)
        begin
            exp_valid = '0;   // bubble
            exp_wb_en = '0;
        end
        else
        begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
                exp_valid[l]   = valid_i[l] && !(l == 1 && kill);
                exp_wb_en[l]   = exp_valid[l] && wb_en_i[l] && (op_i[l] != OP_ST) &&
                                 (op_i[l] != OP_BEQ) && (op_i[l] != OP_BNE);
                exp_wb_addr[l] = wb_addr_i[l];
                exp_wb_data[l] = lane_value(op_i[l], src1_i[l], src2_i[l], imm_i[l]);
            end
            if (valid_i[0] && is_div(op_i[0]))
                check_word("pause_ex_o high cycles", word_t'(stall_run), word_t'(DIV_CYCLES));
        end
        if (retire)
            div_age = 0;
        else if (valid_i[0] && is_div(op_i[0]) && div_age < DIV_CYCLES)
            div_age++;
    endtask

    task automatic check_regs();
        for (int l = 0; l < NUM_LANES; l++)
        begin
            check_bit($sformatf("mem_valid_o[%0d]", l), mem_valid_o[l], exp_valid[l]);
            check_bit($sformatf("mem_wb_en_o[%0d]", l), mem_wb_en_o[l], exp_wb_en[l]);
            if (exp_valid[l])
                check_word($sformatf("mem_wb_addr_o[%0d]", l),
                           word_t'(mem_wb_addr_o[l]), word_t'(exp_wb_addr[l]));
            if (exp_valid[l] && exp_wb_en[l])
                check_word($sformatf("mem_wb_data_o[%0d]", l), mem_wb_data_o[l], exp_wb_data[l]);
        end
    endtask

    initial
    begin
        seed          = 32'h0e1e_b0ea;
        errors        = 0;
        checks        = 0;
        retired       = 0;
        div_age       = 0;
        stall_run     = 0;
        exp_valid     = '0;
        exp_wb_en     = '0;
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        pause_mem_i   = 1'b0;
        dcache_busy_i = 1'b0;
        valid_i       = '0;
        wb_en_i       = '0;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            pc_i[l]      = '0;
            op_i[l]      = OP_NOP;
            src1_i[l]    = '0;
            src2_i[l]    = '0;
            imm_i[l]     = '0;
            wb_addr_i[l] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        check_regs();   // state right after reset
        check_bit("pause_ex_o", pause_ex_o, 1'b0);
        check_bit("branch_flush_o", branch_flush_o, 1'b0);
        check_bit("dc_ren_o", dc_ren_o, 1'b0);
        reset_i = 1'b0;
        draw_bundle();
        draw_controls();
        while (retired < NUM_BUNDLES)
        begin
            #2;   // one ns before the edge with inputs settled
            check_comb();
            if (pause_ex_o)
                stall_run++;
            update_model();
            @(posedge clk);
            #1;
            check_regs();
            if (retire)
            begin
                retired++;
                stall_run = 0;
                draw_bundle();
            end
            draw_controls();
        end
        errors = errors + uut.u_assertions.assert_errors;
        $display("checks: %0d  errors: %0d  assertion errors: %0d",
                 checks, errors, uut.u_assertions.assert_errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* dv/exe_stage_assertions.sv */
`timescale 1ns/100ps

module exe_stage_assertions (
    input logic                          clk,
    input logic                          reset_i,
    input logic                          flush_i,
    input logic                          dcache_busy_i,
    input logic                          dc_ren_i,
    input logic [3:0]                    dc_wstrb_i,
    input exe_pkg::word_t                dc_addr_i,
    input exe_pkg::word_t                dc_wdata_i,
    input logic                          pause_ex_i,
    input logic                          branch_flush_i,
    input logic [exe_pkg::NUM_LANES-1:0] mem_valid_i
);

    int assert_errors = 0;   // failures seen so far

    // cache port stays idle while the cache is busy
    property dcache_quiet_p;
        @(posedge clk) disable iff (reset_i)
            dcache_busy_i |-> (!dc_ren_i && dc_wstrb_i == 4'h0 &&
                               dc_addr_i == '0 && dc_wdata_i == '0);
    endproperty

    property flush_not_stalled_p;
        @(posedge clk) disable iff (reset_i)
            !(branch_flush_i && pause_ex_i);
    endproperty

    property flush_clears_p;
        @(posedge clk) flush_i |=> (mem_valid_i == '0);   // EX/MEM empty after a flush
    endproperty

    dcache_quiet_a: assert property (dcache_quiet_p)
    else
    begin
        assert_errors = assert_errors + 1;
        $error("dcache request driven while dcache_busy_i is high");
    end

    flush_not_stalled_a: assert property (flush_not_stalled_p)
    else
    begin
        assert_errors = assert_errors + 1;
        $error("branch_flush_o raised during an execute stall");
    end

    flush_clears_a: assert property (flush_clears_p)
    else
    begin
        assert_errors = assert_errors + 1;
        $error("mem_valid_o not cleared the cycle after flush_i");
    end

endmodule

/* logic/exe_stage.sv */
`timescale 1ns/100ps

module exe_stage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic                          pause_mem_i,
    input  logic                          dcache_busy_i,
    input  logic [exe_pkg::NUM_LANES-1:0] valid_i,
    input  exe_pkg::word_t                pc_i      [exe_pkg::NUM_LANES],
    input  exe_pkg::alu_op_e              op_i      [exe_pkg::NUM_LANES],
    input  exe_pkg::word_t                src1_i    [exe_pkg::NUM_LANES],
    input  exe_pkg::word_t                src2_i    [exe_pkg::NUM_LANES],
    input  exe_pkg::word_t                imm_i     [exe_pkg::NUM_LANES],
    input  logic [exe_pkg::NUM_LANES-1:0] wb_en_i,
    input  exe_pkg::reg_addr_t            wb_addr_i [exe_pkg::NUM_LANES],
    output logic                          dc_ren_o,
    output logic [3:0]                    dc_wstrb_o,
    output exe_pkg::word_t                dc_addr_o,
    output exe_pkg::word_t                dc_wdata_o,
    output logic                          pause_ex_o,
    output logic                          branch_flush_o,
    output exe_pkg::word_t                branch_target_o,
    output logic [exe_pkg::NUM_LANES-1:0] mem_valid_o,
    output logic [exe_pkg::NUM_LANES-1:0] mem_wb_en_o,
    output exe_pkg::reg_addr_t            mem_wb_addr_o [exe_pkg::NUM_LANES],
    output exe_pkg::word_t                mem_wb_data_o [exe_pkg::NUM_LANES]
);
    import exe_pkg::*;

    logic  div_busy;
    logic  div_load;
    logic  div_step;
    logic  div_done;
    word_t div_result;

    lane_result_if lane0_res ();
    lane_result_if lane1_res ();

    ex_lane u_lane0 (
        .valid_i   (valid_i[0]),
        .pc_i      (pc_i[0]),
        .op_i      (op_i[0]),
        .src1_i    (src1_i[0]),
        .src2_i    (src2_i[0]),
        .imm_i     (imm_i[0]),
        .wb_en_i   (wb_en_i[0]),
        .wb_addr_i (wb_addr_i[0]),
        .res       (lane0_res)
    );

    ex_lane u_lane1 (
        .valid_i   (valid_i[1]),
        .pc_i      (pc_i[1]),
        .op_i      (op_i[1]),
        .src1_i    (src1_i[1]),
        .src2_i    (src2_i[1]),
        .imm_i     (imm_i[1]),
        .wb_en_i   (wb_en_i[1]),
        .wb_addr_i (wb_addr_i[1]),
        .res       (lane1_res)
    );

    // shared divider for lane 0 only
    div_ctrl #(
        .WIDTH (exe_pkg::XLEN)
    ) u_div_ctrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .pause_mem_i (pause_mem_i),
        .lane0       (lane0_res),
        .busy_o      (div_busy),
        .load_o      (div_load),
        .step_o      (div_step),
        .done_o      (div_done)
    );

    div_datapath #(
        .WIDTH (exe_pkg::XLEN)
    ) u_div_datapath (
        .clk      (clk),
        .load_i   (div_load),
        .step_i   (div_step),
        .lane0    (lane0_res),
        .result_o (div_result)
    );

    ex_resolve u_resolve (
        .dcache_busy_i   (dcache_busy_i),
        .div_busy_i      (div_busy),
        .pause_mem_i     (pause_mem_i),
        .lane0           (lane0_res),
        .lane1           (lane1_res),
        .dc_ren_o        (dc_ren_o),
        .dc_wstrb_o      (dc_wstrb_o),
        .dc_addr_o       (dc_addr_o),
        .dc_wdata_o      (dc_wdata_o),
        .pause_ex_o      (pause_ex_o),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .pause_mem_i   (pause_mem_i),
        .pause_ex_i    (pause_ex_o),
        .div_done_i    (div_done),
        .div_result_i  (div_result),
        .lane0         (lane0_res),
        .lane1         (lane1_res),
        .mem_valid_o   (mem_valid_o),
        .mem_wb_en_o   (mem_wb_en_o),
        .mem_wb_addr_o (mem_wb_addr_o),
        .mem_wb_data_o (mem_wb_data_o)
    );

endmodule

/* logic/ex_mem_reg.sv */
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic                          pause_mem_i,
    input  logic                          pause_ex_i,
    input  logic                          div_done_i,
    input  exe_pkg::word_t                div_result_i,
    lane_result_if.consumer               lane0,
    lane_result_if.consumer               lane1,
    output logic [exe_pkg::NUM_LANES-1:0] mem_valid_o,
    output logic [exe_pkg::NUM_LANES-1:0] mem_wb_en_o,
    output exe_pkg::reg_addr_t            mem_wb_addr_o [exe_pkg::NUM_LANES],
    output exe_pkg::word_t                mem_wb_data_o [exe_pkg::NUM_LANES]
);

    logic advance;
    logic kill_lane1;

    assign advance    = !pause_mem_i && !pause_ex_i;
    assign kill_lane1 = lane0.br_taken;   // younger lane sits on the wrong path

    always_ff @(posedge clk)
    begin
        if (reset_i || flush_i)
        begin
            mem_valid_o <= '0;
            mem_wb_en_o <= '0;
        end
        else if (pause_mem_i)
        begin
            mem_valid_o <= mem_valid_o;   // hold while mem stage not ready
            mem_wb_en_o <= mem_wb_en_o;
        end
        else if (pause_ex_i)
        begin
            mem_valid_o <= '0;            // bubble
            mem_wb_en_o <= '0;
        end
        else
        begin
            mem_valid_o[0] <= lane0.valid;
            mem_wb_en_o[0] <= lane0.wb_en;
            mem_valid_o[1] <= lane1.valid && !kill_lane1;
            mem_wb_en_o[1] <= lane1.wb_en && !kill_lane1;
        end
    end

    // payload loads whenever the bundle advances
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            mem_wb_addr_o[0] <= lane0.wb_addr;
            mem_wb_data_o[0] <= div_done_i ? div_result_i : lane0.wb_data;
            mem_wb_addr_o[1] <= lane1.wb_addr;
            mem_wb_data_o[1] <= lane1.wb_data;
        end
    end

endmodule

/* logic/ex_resolve.sv */
`timescale 1ns/100ps

module ex_resolve (
    input  logic            dcache_busy_i,
    input  logic            div_busy_i,
    input  logic            pause_mem_i,
    lane_result_if.consumer lane0,
    lane_result_if.consumer lane1,
    output logic            dc_ren_o,
    output logic [3:0]      dc_wstrb_o,
    output exe_pkg::word_t  dc_addr_o,
    output exe_pkg::word_t  dc_wdata_o,
    output logic            pause_ex_o,
    output logic            branch_flush_o,
    output exe_pkg::word_t  branch_target_o
);
    import exe_pkg::*;

    logic  lane0_mem;
    logic  lane1_mem;
    logic  mem_active;
    logic  dc_quiet;
    logic  sel_ren;
    logic  sel_we;
    word_t sel_addr;
    word_t sel_wdata;

    assign lane0_mem  = lane0.mem_ren || lane0.mem_we;
    assign lane1_mem  = lane1.mem_ren || lane1.mem_we;
    assign mem_active = lane0_mem || lane1_mem;

    // dispatch never pairs memory ops so lane 0 simply wins
    always_comb
    begin
        if (lane0_mem)
        begin
            sel_ren   = lane0.mem_ren;
            sel_we    = lane0.mem_we;
            sel_addr  = lane0.mem_addr;
            sel_wdata = lane0.mem_wdata;
        end
        else
        begin
            sel_ren   = lane1.mem_ren;
            sel_we    = lane1.mem_we;
            sel_addr  = lane1.mem_addr;
            sel_wdata = lane1.mem_wdata;
        end
    end

    assign dc_quiet   = dcache_busy_i || !mem_active;   // port idles while cache is busy
    assign dc_ren_o   = dc_quiet ? 1'b0 : sel_ren;
    assign dc_wstrb_o = (dc_quiet || !sel_we) ? 4'h0 : WSTRB_FULL;
    assign dc_addr_o  = dc_quiet ? '0 : sel_addr;
    assign dc_wdata_o = (dc_quiet || !sel_we) ? '0 : sel_wdata;

    assign pause_ex_o = (mem_active && dcache_busy_i) || div_busy_i;

    // redirect only once the bundle actually leaves execute
    assign branch_flush_o  = (lane0.br_taken || lane1.br_taken) && !pause_ex_o && !pause_mem_i;
    assign branch_target_o = lane0.br_taken ? lane0.br_target : lane1.br_target;

endmodule

/* logic/div_datapath.sv */
`timescale 1ns/100ps

module div_datapath #(
    parameter int WIDTH = 32
) (
    input  logic            clk,
    input  logic            load_i,
    input  logic            step_i,
    lane_result_if.consumer lane0,
    output exe_pkg::word_t  result_o
);
    import exe_pkg::*;

    logic [WIDTH-1:0] rem_q;       // partial remainder
    logic [WIDTH-1:0] quo_q;       // dividend bits shift out as quotient bits shift in
    logic [WIDTH-1:0] divisor_q;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   trial;

    // next dividend bit joins the partial remainder
    assign shifted = {rem_q, quo_q[WIDTH-1]};
    assign trial   = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk)
    begin
        if (load_i)
        begin
            rem_q     <= '0;
            quo_q     <= lane0.div_a[WIDTH-1:0];
            divisor_q <= lane0.div_b[WIDTH-1:0];
        end
        else if (step_i)
        begin
            if (trial[WIDTH])   // went negative so restore
            begin
                rem_q <= shifted[WIDTH-1:0];
                quo_q <= {quo_q[WIDTH-2:0], 1'b0};
            end
            else
            begin
                rem_q <= trial[WIDTH-1:0];
                quo_q <= {quo_q[WIDTH-2:0], 1'b1};
            end
        end
    end

    // zero divisor never goes negative and leaves all-ones quotient and the dividend
    assign result_o = lane0.div_rem ? word_t'(rem_q) : word_t'(quo_q);

endmodule

/* logic/div_ctrl.sv */
`timescale 1ns/100ps

module div_ctrl #(
    parameter int WIDTH = 32
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            flush_i,
    input  logic            pause_mem_i,
    lane_result_if.consumer lane0,
    output logic            busy_o,
    output logic            load_o,
    output logic            step_o,
    output logic            done_o
);

    localparam int CNT_W = $clog2(WIDTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic [CNT_W-1:0] cnt_q;      // shift-subtract steps taken so far
    logic             last_step;

    assign last_step = (cnt_q == CNT_W'(WIDTH - 1));

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
                if (lane0.div_req)
                    state_d = S_BUSY;
            S_BUSY:
                if (last_step)
                    state_d = S_DONE;
            S_DONE:
                if (!pause_mem_i)
                    state_d = S_IDLE;   // result goes into EX/MEM now
            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i || flush_i)
            state_q <= S_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
            cnt_q <= '0;
        else if (load_o)
            cnt_q <= '0;
        else if (step_o)
            cnt_q <= cnt_q + 1'b1;
    end

    // stall covers the request cycle plus every step
    assign load_o = (state_q == S_IDLE) && lane0.div_req;
    assign step_o = (state_q == S_BUSY);
    assign busy_o = load_o || step_o;
    assign done_o = (state_q == S_DONE);

endmodule

/* logic/ex_lane.sv */
`timescale 1ns/100ps

module ex_lane (
    input  logic               valid_i,
    input  exe_pkg::word_t     pc_i,
    input  exe_pkg::alu_op_e   op_i,
    input  exe_pkg::word_t     src1_i,
    input  exe_pkg::word_t     src2_i,
    input  exe_pkg::word_t     imm_i,
    input  logic               wb_en_i,
    input  exe_pkg::reg_addr_t wb_addr_i,
    lane_result_if.lane        res
);
    import exe_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    word_t alu_result;
    word_t addr;
    logic  is_branch;
    logic  is_load;
    logic  is_store;
    logic  is_div;
    logic  src_equal;
    logic  cond_met;

    assign addr      = src1_i + imm_i;   // load/store effective address
    assign src_equal = (src1_i == src2_i);

    assign is_branch = (op_i == OP_BEQ) || (op_i == OP_BNE);
    assign is_load   = (op_i == OP_LD);
    assign is_store  = (op_i == OP_ST);
    assign is_div    = (op_i == OP_DIVU) || (op_i == OP_REMU);

    assign cond_met  = (op_i == OP_BEQ) ? src_equal : !src_equal;

    always_comb
    begin
        alu_result = '0;
        case (op_i)
            OP_ADD:  alu_result = src1_i + src2_i;
            OP_SUB:  alu_result = src1_i - src2_i;
            OP_AND:  alu_result = src1_i & src2_i;
            OP_OR:   alu_result = src1_i | src2_i;
            OP_XOR:  alu_result = src1_i ^ src2_i;
            OP_SLL:  alu_result = src1_i << src2_i[SHAMT_W-1:0];
            OP_SRL:  alu_result = src1_i >> src2_i[SHAMT_W-1:0];
            OP_SLT:  alu_result = word_t'($signed(src1_i) < $signed(src2_i));
            OP_LD:   alu_result = addr;    // mem stage picks the address up here
            default: alu_result = '0;      // divide result is patched in later
        endcase
    end

    assign res.valid     = valid_i;
    // branches and stores never write the register file
    assign res.wb_en     = valid_i && wb_en_i && !is_branch && !is_store;
    assign res.wb_addr   = wb_addr_i;
    assign res.wb_data   = alu_result;

    assign res.mem_ren   = valid_i && is_load;
    assign res.mem_we    = valid_i && is_store;
    assign res.mem_addr  = addr;
    assign res.mem_wdata = src2_i;

    assign res.br_taken  = valid_i && is_branch && cond_met;
    assign res.br_target = pc_i + imm_i;

    assign res.div_req   = valid_i && is_div;
    assign res.div_rem   = (op_i == OP_REMU);
    assign res.div_a     = src1_i;
    assign res.div_b     = src2_i;

endmodule

/* logic/lane_result_if.sv */
`timescale 1ns/100ps

interface lane_result_if;
    import exe_pkg::*;

    logic      valid;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // dcache request flags already qualified by valid
    logic      mem_ren;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_wdata;

    logic      br_taken;
    word_t     br_target;

    logic      div_req;
    logic      div_rem;   // remainder instead of quotient
    word_t     div_a;     // dividend
    word_t     div_b;     // divisor

    modport lane (
        output valid, wb_en, wb_addr, wb_data,
        output mem_ren, mem_we, mem_addr, mem_wdata,
        output br_taken, br_target,
        output div_req, div_rem, div_a, div_b
    );

    modport consumer (
        input valid, wb_en, wb_addr, wb_data,
        input mem_ren, mem_we, mem_addr, mem_wdata,
        input br_taken, br_target,
        input div_req, div_rem, div_a, div_b
    );

endinterface

/* logic/exe_pkg.sv */
package exe_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_LANES = 2;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;   // register file write address

    // operation code as decoded by dispatch
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_SLT  = 4'd8,   // signed compare
        OP_BEQ  = 4'd9,
        OP_BNE  = 4'd10,
        OP_LD   = 4'd11,
        OP_ST   = 4'd12,
        OP_DIVU = 4'd13,  // lane 0 only
        OP_REMU = 4'd14
    } alu_op_e;

    // word store writes all four bytes
    localparam logic [3:0] WSTRB_FULL = 4'b1111;

endpackage
